//--- huff_cfg_pkg.sv
`default_nettype none

package huff_cfg_pkg;

    // Gray levels 1 to 6 are coded
    parameter int SYM_COUNT = 6;

    // Counts and merged weights
    parameter int CNT_W = 8;

    // A code and its mask share one width
    parameter int CODE_W = 8;

    // Ids 0 to 5 for leaves, 6 to 10 for merged groups
    parameter int GRP_W = 4;

endpackage

`default_nettype wire

//--- huff_types_pkg.sv
`default_nettype none

package huff_types_pkg;

    // Slot 0 holds the count of gray level 1
    typedef logic [huff_cfg_pkg::SYM_COUNT-1:0][huff_cfg_pkg::CNT_W-1:0] count_vec_t;

    typedef struct packed {
        logic [huff_cfg_pkg::CNT_W-1:0] weight; // Weight of the whole group
        logic [huff_cfg_pkg::GRP_W-1:0] grp;    // Group the symbol belongs to
    } node_t;

    typedef node_t [huff_cfg_pkg::SYM_COUNT-1:0] node_table_t;

    // Symbol indexes of the two picks of one merge
    typedef struct packed {
        logic [$clog2(huff_cfg_pkg::SYM_COUNT)-1:0] first;
        logic [$clog2(huff_cfg_pkg::SYM_COUNT)-1:0] second;
    } pair_t;

    typedef struct packed {
        logic [huff_cfg_pkg::CODE_W-1:0] code;
        logic [huff_cfg_pkg::CODE_W-1:0] mask; // Low ones, one per code bit
    } code_entry_t;

    typedef code_entry_t [huff_cfg_pkg::SYM_COUNT-1:0] code_table_t;

endpackage

`default_nettype wire

//--- huff_symbol_counter.sv
`timescale 1ns/1ps
`default_nettype none

module huff_symbol_counter #(
    parameter int SYM_COUNT = huff_cfg_pkg::SYM_COUNT,
    parameter int CNT_W     = huff_cfg_pkg::CNT_W
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [7:0]               gray_data,
    input  logic                     count_clear,
    input  logic                     count_en,
    output huff_types_pkg::count_vec_t counts
);

    logic [CNT_W-1:0]     cnt_q [SYM_COUNT];
    logic [SYM_COUNT-1:0] sym_hit;

    // One-hot decode of the gray level that stays zero outside 1 to 6
    always_comb
    begin
        for (int i = 0; i < SYM_COUNT; i++)
        begin
            sym_hit[i] = (gray_data == 8'(i + 1));
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < SYM_COUNT; i++)
            begin
                cnt_q[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < SYM_COUNT; i++)
            begin
                if (count_clear)
                begin
                    // First sample of a new burst still counts
                    cnt_q[i] <= (count_en && sym_hit[i]) ? CNT_W'(1) : '0;
                end
                else if (count_en && sym_hit[i])
                begin
                    cnt_q[i] <= cnt_q[i] + CNT_W'(1);
                end
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < SYM_COUNT; i++)
        begin
            counts[i] = cnt_q[i];
        end
    end

endmodule

`default_nettype wire

//--- huff_pair_finder.sv
`timescale 1ns/1ps
`default_nettype none

module huff_pair_finder #(
    parameter int SYM_COUNT = huff_cfg_pkg::SYM_COUNT,
    parameter int CNT_W     = huff_cfg_pkg::CNT_W
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        scan_start,
    input  huff_types_pkg::node_table_t nodes,
    output huff_types_pkg::pair_t       pair,
    output logic                        scan_done
);

    localparam int IDX_W = $clog2(SYM_COUNT);

    logic                           busy_q;
    logic                           phase_q;  // 0 finds the first pick, 1 the second
    logic                           have_q;   // A candidate is held in this pass
    logic [IDX_W-1:0]               idx_q;
    logic [IDX_W-1:0]               first_q;
    logic [IDX_W-1:0]               second_q;
    logic [CNT_W-1:0]               best_w_q;
    logic [huff_cfg_pkg::GRP_W-1:0] best_g_q;

    huff_types_pkg::node_t cand;
    logic                  excluded;
    logic                  take;

    assign cand     = nodes[idx_q];
    assign excluded = phase_q && (cand.grp == nodes[first_q].grp);

    // Lighter wins, equal weight goes to the larger group id
    assign take = !excluded &&
                  (!have_q || (cand.weight < best_w_q) ||
                   ((cand.weight == best_w_q) && (cand.grp > best_g_q)));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy_q    <= 1'b0;
            phase_q   <= 1'b0;
            have_q    <= 1'b0;
            idx_q     <= '0;
            scan_done <= 1'b0;
        end
        else
        begin
            scan_done <= 1'b0;
            if (scan_start)
            begin
                busy_q  <= 1'b1;
                phase_q <= 1'b0;
                have_q  <= 1'b0;
                idx_q   <= '0;
            end
            else if (busy_q)
            begin
                if (take)
                begin
                    have_q <= 1'b1;
                end
                if (idx_q == IDX_W'(SYM_COUNT - 1))
                begin
                    idx_q  <= '0;
                    have_q <= 1'b0;
                    if (phase_q)
                    begin
                        busy_q    <= 1'b0;
                        scan_done <= 1'b1;
                    end
                    phase_q <= 1'b1;
                end
                else
                begin
                    idx_q <= idx_q + IDX_W'(1);
                end
            end
        end
    end

    // Picks settle by the time scan_done pulses
    always_ff @(posedge clk)
    begin
        if (busy_q && take)
        begin
            best_w_q <= cand.weight;
            best_g_q <= cand.grp;
            if (phase_q)
            begin
                second_q <= idx_q;
            end
            else
            begin
                first_q <= idx_q;
            end
        end
    end

    assign pair.first  = first_q;
    assign pair.second = second_q;

endmodule

`default_nettype wire

//--- huff_code_builder.sv
`timescale 1ns/1ps
`default_nettype none

module huff_code_builder #(
    parameter int SYM_COUNT = huff_cfg_pkg::SYM_COUNT,
    parameter int CNT_W     = huff_cfg_pkg::CNT_W
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load_nodes,
    input  logic                        merge_en,
    input  huff_types_pkg::count_vec_t  counts,
    input  huff_types_pkg::pair_t       pair,
    output huff_types_pkg::node_table_t nodes,
    output huff_types_pkg::code_table_t codes
);

    localparam int CODE_W = huff_cfg_pkg::CODE_W;
    localparam int GRP_W  = huff_cfg_pkg::GRP_W;
    localparam int LEN_W  = $clog2(CODE_W);

    logic [CNT_W-1:0]  weight_q [SYM_COUNT];
    logic [GRP_W-1:0]  grp_q    [SYM_COUNT];
    logic [CODE_W-1:0] code_q   [SYM_COUNT];
    logic [LEN_W-1:0]  len_q    [SYM_COUNT];
    logic [GRP_W-1:0]  next_group;

    logic [GRP_W-1:0] grp_first;
    logic [GRP_W-1:0] grp_second;
    logic [CNT_W-1:0] sum_w;

    assign grp_first  = grp_q[pair.first];
    assign grp_second = grp_q[pair.second];
    assign sum_w      = weight_q[pair.first] + weight_q[pair.second];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            next_group <= GRP_W'(SYM_COUNT);
        end
        else if (load_nodes)
        begin
            next_group <= GRP_W'(SYM_COUNT); // First merged id follows the leaves
        end
        else if (merge_en)
        begin
            next_group <= next_group + GRP_W'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < SYM_COUNT; i++)
        begin
            if (load_nodes)
            begin
                weight_q[i] <= counts[i];
                grp_q[i]    <= GRP_W'(i);
                code_q[i]   <= '0;
                len_q[i]    <= '0;
            end
            else if (merge_en && (grp_q[i] == grp_first || grp_q[i] == grp_second))
            begin
                // First pick gets the 1 branch
                code_q[i][len_q[i]] <= (grp_q[i] == grp_first);
                len_q[i]            <= len_q[i] + LEN_W'(1);
                weight_q[i]         <= sum_w;
                grp_q[i]            <= next_group;
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < SYM_COUNT; i++)
        begin
            nodes[i].weight = weight_q[i];
            nodes[i].grp    = grp_q[i];
            codes[i].code   = code_q[i];
            codes[i].mask   = ~({CODE_W{1'b1}} << len_q[i]);
        end
    end

endmodule

`default_nettype wire

//--- huff_control.sv
`timescale 1ns/1ps
`default_nettype none

module huff_control #(
    parameter int SYM_COUNT = huff_cfg_pkg::SYM_COUNT
)
(
    input  logic clk,
    input  logic reset,
    input  logic gray_valid,
    input  logic scan_done,
    output logic count_clear,
    output logic count_en,
    output logic load_nodes,
    output logic scan_start,
    output logic merge_en,
    output logic cnt_valid,
    output logic code_valid
);

    localparam int RND_W = $clog2(SYM_COUNT);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_publish,
        st_scan,
        st_merge,
        st_done
    } state_t;

    state_t           state_q;
    state_t           state_d;
    logic [RND_W-1:0] round_q;
    logic             last_round;

    // SYM_COUNT-1 merges leave a single group
    assign last_round = (round_q == RND_W'(SYM_COUNT - 2));

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            st_idle:    if (gray_valid) state_d = st_read;
            st_read:    if (!gray_valid) state_d = st_publish;
            st_publish: state_d = st_scan;
            st_scan:    if (scan_done) state_d = st_merge;
            st_merge:   state_d = last_round ? st_done : st_scan;
            st_done:    state_d = st_idle;
            default:    state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state_q    <= st_idle;
            round_q    <= '0;
            scan_start <= 1'b0;
        end
        else
        begin
            state_q    <= state_d;
            scan_start <= (state_d == st_scan) && (state_q != st_scan); // Once per round
            if (state_q == st_publish)
            begin
                round_q <= '0;
            end
            else if (state_q == st_merge)
            begin
                round_q <= round_q + RND_W'(1);
            end
        end
    end

    assign count_clear = (state_q == st_idle) && gray_valid;
    assign count_en    = gray_valid && (state_q == st_idle || state_q == st_read);
    assign load_nodes  = (state_q == st_publish);
    assign cnt_valid   = (state_q == st_publish);
    assign merge_en    = (state_q == st_merge);
    assign code_valid  = (state_q == st_done);

endmodule

`default_nettype wire

//--- huffman_top.sv
`timescale 1ns/1ps
`default_nettype none

module huffman_top #(
    parameter int SYM_COUNT = huff_cfg_pkg::SYM_COUNT,
    parameter int CNT_W     = huff_cfg_pkg::CNT_W
)
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [7:0]                  gray_data,
    input  logic                        gray_valid,
    output logic                        cnt_valid,
    output huff_types_pkg::count_vec_t  counts,
    output logic                        code_valid,
    output huff_types_pkg::code_table_t codes
);

    logic count_clear;
    logic count_en;
    logic load_nodes;
    logic scan_start;
    logic scan_done;
    logic merge_en;

    huff_types_pkg::node_table_t nodes;
    huff_types_pkg::pair_t       pair;

    huff_control #(
        .SYM_COUNT (SYM_COUNT)
    ) u_control (
        .clk         (clk),
        .reset       (reset),
        .gray_valid  (gray_valid),
        .scan_done   (scan_done),
        .count_clear (count_clear),
        .count_en    (count_en),
        .load_nodes  (load_nodes),
        .scan_start  (scan_start),
        .merge_en    (merge_en),
        .cnt_valid   (cnt_valid),
        .code_valid  (code_valid)
    );

    huff_symbol_counter #(
        .SYM_COUNT (SYM_COUNT),
        .CNT_W     (CNT_W)
    ) u_counter (
        .clk         (clk),
        .reset       (reset),
        .gray_data   (gray_data),
        .count_clear (count_clear),
        .count_en    (count_en),
        .counts      (counts)
    );

    huff_pair_finder #(
        .SYM_COUNT (SYM_COUNT),
        .CNT_W     (CNT_W)
    ) u_finder (
        .clk        (clk),
        .reset      (reset),
        .scan_start (scan_start),
        .nodes      (nodes),
        .pair       (pair),
        .scan_done  (scan_done)
    );

    huff_code_builder #(
        .SYM_COUNT (SYM_COUNT),
        .CNT_W     (CNT_W)
    ) u_builder (
        .clk        (clk),
        .reset      (reset),
        .load_nodes (load_nodes),
        .merge_en   (merge_en),
        .counts     (counts),
        .pair       (pair),
        .nodes      (nodes),
        .codes      (codes)
    );

endmodule

`default_nettype wire

//--- huffman_tb.sv
`timescale 1ns/1ps
`default_nettype none

module huffman_tb;

    localparam int RAND_SEED    = 32'h4f7c4ab3;
    localparam int NSYM         = huff_cfg_pkg::SYM_COUNT;
    localparam int NGRP         = 2 * NSYM - 1;  // Leaves plus merged groups
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 40;
    localparam int NUM_DIRECTED = 4;
    localparam int MAX_LEN      = 200;
    localparam int FRAME_SLACK  = 150;  // Publish, five rounds, idle gap
    localparam int TIMEOUT_CYCLES =
        (NUM_RANDOM + NUM_DIRECTED) * (MAX_LEN + FRAME_SLACK) + RESET_CYCLES + 16;

    logic                        clk;
    logic                        reset;
    logic [7:0]                  gray_data;
    logic                        gray_valid;
    logic                        cnt_valid;
    logic                        code_valid;
    huff_types_pkg::count_vec_t  counts;
    huff_types_pkg::code_table_t codes;

    logic [7:0]  samples [$];
    int          model_counts [NSYM];
    logic [7:0]  model_code [NSYM];
    int          model_len [NSYM];
    int          group_weight [NGRP];
    bit          group_active [NGRP];
    int          cycle_count = 0;
    int unsigned seed_dummy;

    huffman_top dut (
        .clk        (clk),
        .reset      (reset),
        .gray_data  (gray_data),
        .gray_valid (gray_valid),
        .cnt_valid  (cnt_valid),
        .counts     (counts),
        .code_valid (code_valid),
        .codes      (codes)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Simulation failed");
            $fatal(1, "Timeout, the run did not complete within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("error at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic compare_counts(input string what);
        for (int i = 0; i < NSYM; i++)
        begin
            check_value(32'(counts[i]), 32'(model_counts[i]),
                        $sformatf("%s, symbol %0d", what, i + 1));
        end
    endtask

    task automatic verify_codes();
        for (int i = 0; i < NSYM; i++)
        begin
            check_value(32'(codes[i].mask), 32'((1 << model_len[i]) - 1),
                        $sformatf("mask of symbol %0d", i + 1));
            check_value(32'(codes[i].code), 32'(model_code[i]),
                        $sformatf("code of symbol %0d", i + 1));
        end
    endtask

    // Lightest live group with ties to the larger id
    function automatic int pick_lightest(input int skip);
        int best;
        best = -1;
        for (int g = 0; g < NGRP; g++)
        begin
            if (group_active[g] && g != skip)
            begin
                if (best < 0 || group_weight[g] <= group_weight[best])
                begin
                    best = g;  // Later id wins a tie
                end
            end
        end
        return best;
    endfunction

    task automatic build_model();
        int sym;
        int first_g;
        int second_g;
        int next_id;
        int sym_grp [NSYM];
        for (int i = 0; i < NSYM; i++)
        begin
            model_counts[i] = 0;
            model_code[i]   = '0;
            model_len[i]    = 0;
            sym_grp[i]      = i;
        end
        foreach (samples[k])
        begin
            sym = int'(samples[k]);
            if (sym >= 1 && sym <= NSYM)
            begin
                model_counts[sym - 1]++;
            end
        end
        for (int g = 0; g < NGRP; g++)
        begin
            group_active[g] = (g < NSYM);
            group_weight[g] = (g < NSYM) ? model_counts[g] : 0;
        end
        next_id = NSYM;
        for (int m = 0; m < NSYM - 1; m++)
        begin
            first_g  = pick_lightest(-1);
            second_g = pick_lightest(first_g);
            for (int i = 0; i < NSYM; i++)
            begin
                if (sym_grp[i] == first_g || sym_grp[i] == second_g)
                begin
                    if (sym_grp[i] == first_g)
                    begin
                        model_code[i] = model_code[i] | (8'd1 << model_len[i]);
                    end
                    model_len[i]++;
                    sym_grp[i] = next_id;
                end
            end
            group_weight[next_id]  = group_weight[first_g] + group_weight[second_g];
            group_active[next_id]  = 1'b1;
            group_active[first_g]  = 1'b0;
            group_active[second_g] = 1'b0;
            next_id++;
        end
    endtask

    task automatic add_run(input int sym, input int n);
        for (int k = 0; k < n; k++)
        begin
            samples.push_back(8'(sym));
        end
    endtask

    // Junk on gray_data must not touch the held counts
    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++)
        begin
            @(posedge clk);
            gray_valid <= 1'b0;
            gray_data  <= 8'($urandom);
            @(negedge clk);
            check_value(32'(cnt_valid), 32'd0, "cnt_valid while idle");
            check_value(32'(code_valid), 32'd0, "code_valid while idle");
            compare_counts("counts held while idle");
        end
    endtask

    task automatic run_burst();
        int cnt_seen;
        bit code_seen;
        cnt_seen  = 0;
        code_seen = 1'b0;
        build_model();
        foreach (samples[k])
        begin
            @(posedge clk);
            gray_valid <= 1'b1;
            gray_data  <= samples[k];
            @(negedge clk);
            check_value(32'(cnt_valid), 32'd0, "cnt_valid during burst");
            check_value(32'(code_valid), 32'd0, "code_valid during burst");
        end
        @(posedge clk);
        gray_valid <= 1'b0;
        gray_data  <= 8'd0;
        while (!code_seen)
        begin
            @(negedge clk);
            if (cnt_valid)
            begin
                check_value(cnt_seen, 0, "second cnt_valid in one burst");
                compare_counts("counts at cnt_valid");
                cnt_seen++;
            end
            if (code_valid)
            begin
                check_value(cnt_seen, 1, "cnt_valid count before code_valid");
                compare_counts("counts at code_valid");
                verify_codes();
                code_seen = 1'b1;
            end
        end
    endtask

    initial
    begin
        int len;
        seed_dummy = $urandom(RAND_SEED);
        reset      <= 1'b1;
        gray_valid <= 1'b0;
        gray_data  <= 8'd0;
        for (int i = 0; i < NSYM; i++)
        begin
            model_counts[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        idle_cycles(4);

        // All six weights tie
        samples.delete();
        for (int s = 1; s <= NSYM; s++)
        begin
            add_run(s, 3);
        end
        run_burst();
        idle_cycles(1);

        samples.delete();  // Only ignored values so every weight is zero
        add_run(0, 4);
        add_run(7, 2);
        add_run(9, 3);
        run_burst();
        idle_cycles(1);

        samples.delete();  // Four zero-count symbols
        add_run(2, 5);
        add_run(8, 1);
        add_run(5, 5);
        run_burst();
        idle_cycles(1);

        samples.delete();  // Pairwise ties at three weights
        add_run(1, 1);
        add_run(6, 1);
        add_run(3, 2);
        add_run(4, 2);
        add_run(2, 4);
        add_run(5, 4);
        run_burst();

        for (int b = 0; b < NUM_RANDOM; b++)
        begin
            samples.delete();
            len = 1 + int'($urandom % MAX_LEN);
            for (int k = 0; k < len; k++)
            begin
                samples.push_back(8'($urandom % 10));
            end
            idle_cycles(int'($urandom % 3));
            run_burst();
        end
        idle_cycles(2);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- huffman.f
huff_cfg_pkg.sv
huff_types_pkg.sv
huff_symbol_counter.sv
huff_pair_finder.sv
huff_code_builder.sv
huff_control.sv
huffman_top.sv
huffman_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Huffman testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f huffman.f --top-module huffman_tb -o huffman_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/huffman_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation passed"; then
    exit 0
fi
exit 1
